// ==== sources.f ====
logic/mem_stage_pkg.sv
logic/access_decode.sv
logic/data_memory.sv
logic/load_extract.sv
logic/mem_stage.sv
test/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  # package first, the RTL depends on it
  - logic/mem_stage_pkg.sv
  - logic/access_decode.sv
  - logic/data_memory.sv
  - logic/load_extract.sv
  - logic/mem_stage.sv
  - target: test
    files:
      - test/mem_stage_tb.sv

// ==== test/mem_stage_tb.sv ====
`timescale 1ns/10ps

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int clk_period = 8;
    localparam int reset_cycles = 4;
    localparam int n_rows = 26;
    localparam int b2b_loads = 3;
    localparam int random_init = 16;
    localparam int random_ops = 64;
    // two cycles per operation, doubled for margin
    localparam int watchdog_cycles = 2 * (n_rows + b2b_loads + random_ops) * 2 + reset_cycles;

    typedef struct packed {
        logic        we;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [31:0] exp_data;
        logic        exp_fault;
    } row_t;

    logic              clk;
    logic              rst;
    logic              req;
    logic              we;
    mem_funct3_e       funct3;
    logic [xlen-1:0]   addr;
    logic [xlen-1:0]   store_data;
    logic [xlen-1:0]   load_data;
    logic              load_valid;
    logic              fault;

    row_t              rows [n_rows];
    logic [7:0]        ref_mem [4096];
    logic [15:0]       lfsr;
    int                errors;
    int                checks;
    int                tests_run;
    int                tests_failed;

    mem_stage #(
        .MEM_WORDS (1024)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .we         (we),
        .funct3     (funct3),
        .addr       (addr),
        .store_data (store_data),
        .load_data  (load_data),
        .load_valid (load_valid),
        .fault      (fault)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // stops a run that hangs waiting on the DUT
    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired: the run did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11, one new bit per call
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // byte model, little endian, indexed by the low 12 address bits
    task automatic model_store(input logic [31:0] a, input logic [2:0] f3,
                               input logic [31:0] d);
        int n;
        n = 1 << f3[1:0];
        for (int i = 0; i < n; i++) begin
            ref_mem[(a[11:0] + i) & 12'hfff] = d[i*8 +: 8];
        end
    endtask

    function automatic logic [31:0] model_load(input logic [31:0] a, input logic [2:0] f3);
        logic [31:0] v;
        int n;
        v = '0;
        n = 1 << f3[1:0];
        for (int i = 0; i < n; i++) begin
            v[i*8 +: 8] = ref_mem[(a[11:0] + i) & 12'hfff];
        end
        // bit 2 of the code picks zero extension
        if (n == 1 && !f3[2] && v[7]) begin
            v[31:8] = '1;
        end
        if (n == 2 && !f3[2] && v[15]) begin
            v[31:16] = '1;
        end
        return v;
    endfunction

    // one request, caller sits on a falling edge and is left on one
    task automatic run_op(input logic w, input logic [2:0] f3, input logic [31:0] a,
                          input logic [31:0] sd, input logic [31:0] ed, input logic ef);
        logic exp_valid;
        exp_valid = !w && !ef;
        req = 1'b1;
        we = w;
        funct3 = mem_funct3_e'(f3);
        addr = a;
        store_data = sd;
        @(negedge clk);
        req = 1'b0;
        // fault comes one cycle after acceptance, data one cycle later
        check_value("fault", fault, ef);
        if (load_valid) begin
            $display("load_valid came one cycle early at %0t ns", $time);
            errors++;
        end
        @(negedge clk);
        if (load_valid !== exp_valid) begin
            $display("addr %h: load_valid pulse %s at %0t ns", a,
                     exp_valid ? "missing" : "not expected", $time);
            errors++;
        end else if (exp_valid) begin
            check_value("load_data", load_data, ed);
        end
        check_value("fault after pulse", fault, 1'b0);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("%s: %s", name, (errors == errors_before) ? "pass" : "fail");
    endtask

    initial begin
        int e0;
        logic [31:0] b2b_addr [b2b_loads];
        logic [2:0] b2b_f3 [b2b_loads];
        logic [31:0] b2b_exp [b2b_loads];
        logic w;
        logic [2:0] f3;
        logic [1:0] sz;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] ed;

        rst = 1'b1;
        req = 1'b0;
        we = 1'b0;
        funct3 = word;
        addr = '0;
        store_data = '0;
        lfsr = 16'd29898;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;

        // we, funct3, addr, store_data, expected load_data, expected fault
        rows[0]  = '{1'b1, 3'd2, 32'h0000_0100, 32'hdead_beef, 32'h0, 1'b0};
        rows[1]  = '{1'b0, 3'd2, 32'h0000_0100, 32'h0, 32'hdead_beef, 1'b0};
        // byte and halfword merge into the same word
        rows[2]  = '{1'b1, 3'd0, 32'h0000_0101, 32'h0000_005a, 32'h0, 1'b0};
        rows[3]  = '{1'b1, 3'd1, 32'h0000_0102, 32'h0000_1234, 32'h0, 1'b0};
        rows[4]  = '{1'b0, 3'd2, 32'h0000_0100, 32'h0, 32'h1234_5aef, 1'b0};
        // sign and zero extension
        rows[5]  = '{1'b1, 3'd2, 32'h0000_0104, 32'h80f7_8081, 32'h0, 1'b0};
        rows[6]  = '{1'b0, 3'd0, 32'h0000_0104, 32'h0, 32'hffff_ff81, 1'b0};
        rows[7]  = '{1'b0, 3'd4, 32'h0000_0104, 32'h0, 32'h0000_0081, 1'b0};
        rows[8]  = '{1'b0, 3'd1, 32'h0000_0106, 32'h0, 32'hffff_80f7, 1'b0};
        rows[9]  = '{1'b0, 3'd5, 32'h0000_0106, 32'h0, 32'h0000_80f7, 1'b0};
        rows[10] = '{1'b0, 3'd0, 32'h0000_0105, 32'h0, 32'hffff_ff80, 1'b0};
        rows[11] = '{1'b0, 3'd0, 32'h0000_0101, 32'h0, 32'h0000_005a, 1'b0};
        // misaligned and illegal codes
        rows[12] = '{1'b0, 3'd1, 32'h0000_0101, 32'h0, 32'h0, 1'b1};
        rows[13] = '{1'b0, 3'd2, 32'h0000_0102, 32'h0, 32'h0, 1'b1};
        rows[14] = '{1'b1, 3'd2, 32'h0000_0106, 32'h1111_1111, 32'h0, 1'b1};
        rows[15] = '{1'b0, 3'd3, 32'h0000_0100, 32'h0, 32'h0, 1'b1};
        rows[16] = '{1'b0, 3'd6, 32'h0000_0100, 32'h0, 32'h0, 1'b1};
        rows[17] = '{1'b0, 3'd7, 32'h0000_0100, 32'h0, 32'h0, 1'b1};
        rows[18] = '{1'b1, 3'd4, 32'h0000_0104, 32'h0000_00aa, 32'h0, 1'b1};
        rows[19] = '{1'b1, 3'd5, 32'h0000_0104, 32'h0000_bbbb, 32'h0, 1'b1};
        rows[20] = '{1'b0, 3'd2, 32'h0000_0104, 32'h0, 32'h80f7_8081, 1'b0};
        // 4096 bytes up lands on the same word
        rows[21] = '{1'b1, 3'd2, 32'h0000_1208, 32'hcafe_f00d, 32'h0, 1'b0};
        rows[22] = '{1'b0, 3'd2, 32'h0000_0208, 32'h0, 32'hcafe_f00d, 1'b0};
        rows[23] = '{1'b0, 3'd4, 32'h0000_120b, 32'h0, 32'h0000_00ca, 1'b0};
        rows[24] = '{1'b1, 3'd7, 32'h0000_0100, 32'hffff_ffff, 32'h0, 1'b1};
        rows[25] = '{1'b0, 3'd2, 32'h0000_0100, 32'h0, 32'h1234_5aef, 1'b0};

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int i = 0; i < n_rows; i++) begin
            e0 = errors;
            run_op(rows[i].we, rows[i].f3, rows[i].addr, rows[i].sdata,
                   rows[i].exp_data, rows[i].exp_fault);
            finish_test($sformatf("row %0d", i), e0);
        end

        // three loads on consecutive cycles, results trail by two edges
        b2b_addr[0] = 32'h0000_0100;
        b2b_f3[0] = 3'd2;
        b2b_exp[0] = 32'h1234_5aef;
        b2b_addr[1] = 32'h0000_0104;
        b2b_f3[1] = 3'd2;
        b2b_exp[1] = 32'h80f7_8081;
        b2b_addr[2] = 32'h0000_0102;
        b2b_f3[2] = 3'd5;
        b2b_exp[2] = 32'h0000_1234;
        e0 = errors;
        for (int i = 0; i < b2b_loads + 2; i++) begin
            if (i >= 2) begin
                if (!load_valid) begin
                    $display("back-to-back load %0d got no load_valid pulse", i - 2);
                    errors++;
                end else begin
                    check_value("back-to-back load_data", load_data, b2b_exp[i-2]);
                end
            end
            check_value("back-to-back fault", fault, 1'b0);
            if (i < b2b_loads) begin
                req = 1'b1;
                we = 1'b0;
                funct3 = mem_funct3_e'(b2b_f3[i]);
                addr = b2b_addr[i];
            end else begin
                req = 1'b0;
            end
            @(negedge clk);
        end
        if (load_valid) begin
            $display("back-to-back loads gave an extra load_valid pulse");
            errors++;
        end
        finish_test("back-to-back loads", e0);

        // random phase on a 64 byte window, filled first so every load is defined
        e0 = errors;
        for (int i = 0; i < random_ops; i++) begin
            if (i < random_init) begin
                w = 1'b1;
                f3 = 3'd2;
                a = 32'h0000_0800 + i * 4;
            end else begin
                w = next_bit();
                sz = 2'(rand_bits(2));
                if (sz == 2'd3) begin
                    sz = 2'd2;
                end
                f3 = {1'b0, sz};
                if (!w && sz != 2'd2) begin
                    f3[2] = next_bit();
                end
                a = 32'h0000_0800 + rand_bits(4) * 4;
                if (sz == 2'd0) begin
                    a = a + rand_bits(2);
                end else if (sz == 2'd1) begin
                    a = a + rand_bits(1) * 2;
                end
                // random upper bits, the memory wraps every 4096 bytes
                a = a | (rand_bits(20) << 12);
            end
            d = rand_bits(32);
            ed = '0;
            if (w) begin
                model_store(a, f3, d);
            end else begin
                ed = model_load(a, f3);
            end
            run_op(w, f3, a, d, ed, 1'b0);
        end
        finish_test("random loads and stores", e0);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage import mem_stage_pkg::*; #(
    // data memory depth in words, a power of two
    parameter int MEM_WORDS = 1024
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  logic            we,
    input  mem_funct3_e     funct3,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] store_data,
    output logic [xlen-1:0] load_data,
    output logic            load_valid,
    output logic            fault
);

    localparam int idx_bits = $clog2(MEM_WORDS);

    logic                  wr_en;
    logic                  rd_en;
    logic                  bad;
    logic [byte_lanes-1:0] byte_en;
    logic [xlen-1:0]       wr_data;
    logic [xlen-1:0]       rd_word;
    logic                  rd_valid;
    logic [idx_bits-1:0]   word_idx;
    logic [xlen-1:0]       ext_data;

    // load context, travels one cycle with the read
    logic [lane_bits-1:0]  ld_offset;
    mem_funct3_e           ld_funct3;

    // word index from the bits above the byte offset
    // anything higher is dropped, so addresses wrap
    assign word_idx = addr[idx_bits+lane_bits-1:lane_bits];

    access_decode u_decode (
        .req        (req),
        .we         (we),
        .funct3     (funct3),
        .store_data (store_data),
        .addr       (addr),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .byte_en    (byte_en),
        .wr_data    (wr_data),
        .bad        (bad)
    );

    data_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .word_idx (word_idx),
        .byte_en  (byte_en),
        .wr_data  (wr_data),
        .rd_word  (rd_word),
        .rd_valid (rd_valid)
    );

    // capture offset and width on the same edge as the read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            ld_offset <= addr[lane_bits-1:0];
            ld_funct3 <= funct3;
        end
    end

    // one cycle fault pulse for any rejected request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fault <= 1'b0;
        end else begin
            fault <= req && bad;
        end
    end

    load_extract u_extract (
        .rd_word   (rd_word),
        .offset    (ld_offset),
        .funct3    (ld_funct3),
        .load_data (ext_data)
    );

    // output register stage for the extended load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= rd_valid;
        end
    end

    // load_data keeps the last completed load between pulses
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            load_data <= ext_data;
        end
    end

    // a request either faults or completes, never both
    a_valid_fault_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(load_valid && fault)
    ) else $error("mem_stage: load_valid and fault together");

endmodule

// ==== logic/load_extract.sv ====
`timescale 1ns/10ps

module load_extract import mem_stage_pkg::*; (
    input  logic [xlen-1:0]      rd_word,
    input  logic [lane_bits-1:0] offset,
    input  mem_funct3_e          funct3,
    output logic [xlen-1:0]      load_data
);

    logic [xlen-1:0] shifted;
    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;

    // bring the addressed lane down to bit 0
    // offset counts bytes, so scale it by eight
    assign shifted  = rd_word >> {offset, 3'b000};
    assign sel_byte = shifted[7:0];
    assign sel_half = shifted[15:0];

    // extend according to the width code
    always_comb begin
        case (funct3)
            byte_signed: begin
                load_data = {{(xlen-8){sel_byte[7]}}, sel_byte};
            end
            half_signed: begin
                load_data = {{(xlen-16){sel_half[15]}}, sel_half};
            end
            byte_unsigned: begin
                load_data = {{(xlen-8){1'b0}}, sel_byte};
            end
            half_unsigned: begin
                load_data = {{(xlen-16){1'b0}}, sel_half};
            end
            // full word needs no lane select
            default: begin
                load_data = rd_word;
            end
        endcase
    end

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/10ps

module data_memory import mem_stage_pkg::*; #(
    // depth in words, a power of two
    parameter int MEM_WORDS = 1024
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  logic [$clog2(MEM_WORDS)-1:0] word_idx,
    input  logic [byte_lanes-1:0]        byte_en,
    input  logic [xlen-1:0]              wr_data,
    output logic [xlen-1:0]              rd_word,
    output logic                         rd_valid
);

    // word organized storage, bytes little endian inside a word
    logic [xlen-1:0] mem [MEM_WORDS];

    // byte masked write, one lane at a time
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < byte_lanes; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // registered read of the whole word
    // rd_word keeps the last value read until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[word_idx];
        end
    end

    // valid follows the read strobe by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // a write with no lane selected means the decoder lost the size
    a_wr_has_lanes: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (byte_en != '0)
    ) else $error("data_memory: write with empty byte enable");

endmodule

// ==== logic/access_decode.sv ====
`timescale 1ns/10ps

module access_decode import mem_stage_pkg::*; (
    input  logic                  req,
    input  logic                  we,
    input  mem_funct3_e           funct3,
    input  logic [xlen-1:0]       store_data,
    input  logic [xlen-1:0]       addr,
    output logic                  wr_en,
    output logic                  rd_en,
    output logic [byte_lanes-1:0] byte_en,
    output logic [xlen-1:0]       wr_data,
    output logic                  bad
);

    logic [1:0]           size;
    logic                 zext;
    logic                 code_ok;
    logic                 misaligned;
    logic [lane_bits-1:0] offset;

    // split the width code into size and extension flag
    assign size   = funct3[1:0];
    assign zext   = funct3[2];
    assign offset = addr[lane_bits-1:0];

    // size 3 never exists, and zero extension only makes sense
    // for byte and halfword loads
    assign code_ok = (size != 2'b11) && !(zext && (size == size_word)) && !(zext && we);

    // natural alignment check against the low address bits
    always_comb begin
        case (size)
            size_byte: misaligned = 1'b0;
            size_half: misaligned = offset[0];
            default:   misaligned = (offset != '0);
        endcase
    end

    assign bad = !code_ok || misaligned;

    // lane mask for the addressed bytes
    // replicate the store value so every lane already holds it
    always_comb begin
        case (size)
            size_byte: begin
                byte_en = 4'b0001 << offset;
                wr_data = {4{store_data[7:0]}};
            end
            size_half: begin
                byte_en = 4'b0011 << offset;
                wr_data = {2{store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_data = store_data;
            end
        endcase
    end

    // a faulting request touches nothing
    assign wr_en = req && we && !bad;
    assign rd_en = req && !we && !bad;

endmodule

// ==== logic/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // data and address width of the core
    localparam int xlen = 32;

    // byte lanes in one data word
    localparam int byte_lanes = xlen / 8;

    // width of the byte offset inside a word
    localparam int lane_bits = $clog2(byte_lanes);

    // access size, taken from funct3[1:0]
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // RISC-V load/store width code (funct3)
    // bits 1:0 give the size, bit 2 selects zero extension
    // codes 3, 6 and 7 have no entry and are treated as illegal
    // stores only accept the three signed codes
    typedef enum logic [2:0] {
        byte_signed   = 3'd0,
        half_signed   = 3'd1,
        word          = 3'd2,
        byte_unsigned = 3'd4,
        half_unsigned = 3'd5
    } mem_funct3_e;

endpackage
